/* Makefile */
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_ooo_hazard -f ooo_hazard.f -o sim_ooo_hazard
	./obj_dir/sim_ooo_hazard | tee /dev/stderr | grep -q "^TB PASSED$$"

clean:
	rm -rf obj_dir

/* fetch_pc_ctrl.sv */
`default_nettype none

module fetch_pc_ctrl import ooo_hazard_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  pc_en,
  input  logic  npc_sel,
  input  logic  insert_pc,
  input  word_t branch_target,
  input  word_t priv_pc,
  output word_t pc
);

  word_t pc_next;

  // trap insert beats branch, branch beats advance
  always_comb begin
    if (insert_pc) begin
      pc_next = priv_pc;
    end else if (npc_sel) begin
      pc_next = branch_target;
    end else if (pc_en) begin
      pc_next = pc + 32'd4;
    end else begin
      // stalled
      pc_next = pc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

  // targets from hazard and trap logic stay aligned
  a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
    pc[1:0] == 2'b00)
    else $error("misaligned pc %h", pc);

endmodule

`default_nettype wire

/* fu_busy_tracker.sv */
`default_nettype none

module fu_busy_tracker import ooo_hazard_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  logic     dispatch_valid,
  input  fu_type_t dispatch_fu,
  input  logic     dmem_done,
  output logic     busy_au,
  output logic     busy_mul,
  output logic     busy_div,
  output logic     busy_ls
);

  lat_t au_cnt;
  lat_t mul_cnt;
  lat_t div_cnt;
  logic ls_pend;
  logic go_au;
  logic go_mul;
  logic go_div;
  logic go_ls;

  // reload on dispatch, else drain to zero
  function automatic lat_t next_cnt(input logic load, input lat_t lat, input lat_t cnt);
    if (load) begin
      return lat;
    end
    return (cnt == '0) ? cnt : cnt - lat_t'(1);
  endfunction

  // per-class dispatch strobes
  assign go_au  = dispatch_valid && (dispatch_fu == ARITH_S);
  assign go_mul = dispatch_valid && (dispatch_fu == MUL_S);
  assign go_div = dispatch_valid && (dispatch_fu == DIV_S);
  assign go_ls  = dispatch_valid && (dispatch_fu == LOADSTORE_S);

  always_ff @(posedge clk) begin
    if (rst) begin
      au_cnt  <= '0;
      mul_cnt <= '0;
      div_cnt <= '0;
      ls_pend <= 1'b0;
    end else begin
      au_cnt  <= next_cnt(go_au, ARITH_LATENCY, au_cnt);
      mul_cnt <= next_cnt(go_mul, MUL_LATENCY, mul_cnt);
      div_cnt <= next_cnt(go_div, DIV_LATENCY, div_cnt);
      // load/store waits on the memory handshake
      if (go_ls) begin
        ls_pend <= 1'b1;
      end else if (dmem_done) begin
        ls_pend <= 1'b0;
      end
    end
  end

  assign busy_au  = (au_cnt != '0);
  assign busy_mul = (mul_cnt != '0);
  assign busy_div = (div_cnt != '0);
  assign busy_ls  = ls_pend;

  // dispatch must wait for its stall to drop
  a_no_dispatch_busy: assert property (@(posedge clk) disable iff (rst)
    !((go_au && busy_au) || (go_mul && busy_mul) || (go_div && busy_div) || (go_ls && busy_ls)))
    else $error("dispatch to busy unit %0d", dispatch_fu);

endmodule

`default_nettype wire

/* ooo_hazard.f */
ooo_hazard_pkg.sv
fu_busy_tracker.sv
ooo_hazard_unit.sv
prv_exception_ctrl.sv
fetch_pc_ctrl.sv
ooo_hazard_top.sv
tb_ooo_hazard.sv

/* ooo_hazard_pkg.sv */
`default_nettype none

package ooo_hazard_pkg;

  // pc, address and csr data
  typedef logic [31:0] word_t;

  // trap cause code
  typedef logic [3:0] cause_t;

  // configuration register select
  typedef logic [1:0] csr_addr_t;

  // busy countdown, wide enough for the divider
  typedef logic [3:0] lat_t;

  // class of the dispatched instruction
  typedef enum logic [2:0] {
    NONE_S      = 3'd0,
    ARITH_S     = 3'd1,
    MUL_S       = 3'd2,
    DIV_S       = 3'd3,
    LOADSTORE_S = 3'd4
  } fu_type_t;

  // cause codes, lower code wins except env call
  localparam cause_t CAUSE_MAL_INSN   = 4'd0;
  localparam cause_t CAUSE_FAULT_INSN = 4'd1;
  localparam cause_t CAUSE_ILLEGAL    = 4'd2;
  localparam cause_t CAUSE_BREAKPOINT = 4'd3;
  localparam cause_t CAUSE_MAL_L      = 4'd4;
  localparam cause_t CAUSE_FAULT_L    = 4'd5;
  localparam cause_t CAUSE_MAL_S      = 4'd6;
  localparam cause_t CAUSE_FAULT_S    = 4'd7;
  localparam cause_t CAUSE_ENV_M      = 4'd11;
  localparam cause_t CAUSE_INTR       = 4'd15;

  // configuration addresses
  localparam csr_addr_t CSR_MTVEC = 2'd0;
  localparam csr_addr_t CSR_MIE   = 2'd1;

  // unit busy lengths in cycles
  localparam lat_t ARITH_LATENCY = 4'd1;
  localparam lat_t MUL_LATENCY   = 4'd3;
  localparam lat_t DIV_LATENCY   = 4'd8;

  // fetch starts here out of reset
  localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

/* ooo_hazard_top.sv */
`default_nettype none

module ooo_hazard_top import ooo_hazard_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      dispatch_valid,
  input  fu_type_t  dispatch_fu,
  input  logic      dmem_done,
  input  logic      rob_full,
  input  logic      data_hazard,
  input  logic      ifence,
  input  logic      iflushed,
  input  logic      dflushed,
  input  logic      imem_busy,
  input  logic      jump,
  input  logic      branch,
  input  logic      mispredict,
  input  word_t     branch_target,
  input  logic      fault_insn,
  input  logic      mal_insn,
  input  logic      illegal_insn,
  input  logic      breakpoint,
  input  logic      env_m,
  input  logic      fault_l,
  input  logic      mal_l,
  input  logic      fault_s,
  input  logic      mal_s,
  input  logic      ret,
  input  word_t     commit_pc,
  input  word_t     badaddr_i,
  input  word_t     badaddr_d,
  input  logic      ext_intr,
  input  logic      cfg_we,
  input  csr_addr_t cfg_addr,
  input  word_t     cfg_wdata,
  output word_t     pc,
  output logic      stall_au,
  output logic      stall_mu,
  output logic      stall_du,
  output logic      stall_ls,
  output logic      fetch_decode_stall,
  output logic      if_id_flush,
  output logic      id_ex_flush,
  output logic      ifence_flush,
  output logic      insert_pc,
  output word_t     mepc,
  output cause_t    mcause,
  output word_t     mbadaddr
);

  // unit busy flags
  logic   busy_au;
  logic   busy_mul;
  logic   busy_div;
  logic   busy_ls;
  // fetch steering
  logic   pc_en;
  logic   npc_sel;
  word_t  priv_pc;
  // trap handoff
  logic   exc_valid;
  cause_t exc_cause;
  word_t  exc_badaddr;
  logic   intr_req;
  logic   intr_taken;

  fu_busy_tracker u_busy (
    .clk            (clk),
    .rst            (rst),
    .dispatch_valid (dispatch_valid),
    .dispatch_fu    (dispatch_fu),
    .dmem_done      (dmem_done),
    .busy_au        (busy_au),
    .busy_mul       (busy_mul),
    .busy_div       (busy_div),
    .busy_ls        (busy_ls)
  );

  ooo_hazard_unit u_hazard (
    .dispatch_fu        (dispatch_fu),
    .busy_au            (busy_au),
    .busy_mul           (busy_mul),
    .busy_div           (busy_div),
    .busy_ls            (busy_ls),
    .rob_full           (rob_full),
    .data_hazard        (data_hazard),
    .ifence             (ifence),
    .iflushed           (iflushed),
    .dflushed           (dflushed),
    .imem_busy          (imem_busy),
    .jump               (jump),
    .branch             (branch),
    .mispredict         (mispredict),
    .fault_insn         (fault_insn),
    .mal_insn           (mal_insn),
    .illegal_insn       (illegal_insn),
    .breakpoint         (breakpoint),
    .env_m              (env_m),
    .fault_l            (fault_l),
    .mal_l              (mal_l),
    .fault_s            (fault_s),
    .mal_s              (mal_s),
    .ret                (ret),
    .badaddr_i          (badaddr_i),
    .badaddr_d          (badaddr_d),
    .ext_intr           (ext_intr),
    .intr_taken         (intr_taken),
    .stall_au           (stall_au),
    .stall_mu           (stall_mu),
    .stall_du           (stall_du),
    .stall_ls           (stall_ls),
    .fetch_decode_stall (fetch_decode_stall),
    .pc_en              (pc_en),
    .npc_sel            (npc_sel),
    .if_id_flush        (if_id_flush),
    .id_ex_flush        (id_ex_flush),
    .ifence_flush       (ifence_flush),
    .exc_valid          (exc_valid),
    .exc_cause          (exc_cause),
    .exc_badaddr        (exc_badaddr),
    .intr_req           (intr_req)
  );

  // trap state beside the logic it steers
  prv_exception_ctrl u_prv (
    .clk         (clk),
    .rst         (rst),
    .cfg_we      (cfg_we),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .exc_valid   (exc_valid),
    .intr_req    (intr_req),
    .ret         (ret),
    .exc_cause   (exc_cause),
    .exc_badaddr (exc_badaddr),
    .commit_pc   (commit_pc),
    .insert_pc   (insert_pc),
    .intr_taken  (intr_taken),
    .priv_pc     (priv_pc),
    .mepc        (mepc),
    .mbadaddr    (mbadaddr),
    .mcause      (mcause)
  );

  fetch_pc_ctrl u_fetch (
    .clk           (clk),
    .rst           (rst),
    .pc_en         (pc_en),
    .npc_sel       (npc_sel),
    .insert_pc     (insert_pc),
    .branch_target (branch_target),
    .priv_pc       (priv_pc),
    .pc            (pc)
  );

endmodule

`default_nettype wire

/* ooo_hazard_unit.sv */
`default_nettype none

module ooo_hazard_unit import ooo_hazard_pkg::*; (
  input  fu_type_t dispatch_fu,
  input  logic     busy_au,
  input  logic     busy_mul,
  input  logic     busy_div,
  input  logic     busy_ls,
  input  logic     rob_full,
  input  logic     data_hazard,
  input  logic     ifence,
  input  logic     iflushed,
  input  logic     dflushed,
  input  logic     imem_busy,
  input  logic     jump,
  input  logic     branch,
  input  logic     mispredict,
  input  logic     fault_insn,
  input  logic     mal_insn,
  input  logic     illegal_insn,
  input  logic     breakpoint,
  input  logic     env_m,
  input  logic     fault_l,
  input  logic     mal_l,
  input  logic     fault_s,
  input  logic     mal_s,
  input  logic     ret,
  input  word_t    badaddr_i,
  input  word_t    badaddr_d,
  input  logic     ext_intr,
  input  logic     intr_taken,
  output logic     stall_au,
  output logic     stall_mu,
  output logic     stall_du,
  output logic     stall_ls,
  output logic     fetch_decode_stall,
  output logic     pc_en,
  output logic     npc_sel,
  output logic     if_id_flush,
  output logic     id_ex_flush,
  output logic     ifence_flush,
  output logic     exc_valid,
  output cause_t   exc_cause,
  output word_t    exc_badaddr,
  output logic     intr_req
);

  logic structural;
  logic branch_jump;
  logic trap_flow;

  // structural hazard, dispatched class hits a busy unit
  assign stall_au   = (dispatch_fu == ARITH_S) & busy_au;
  assign stall_mu   = (dispatch_fu == MUL_S) & busy_mul;
  assign stall_du   = (dispatch_fu == DIV_S) & busy_div;
  assign stall_ls   = (dispatch_fu == LOADSTORE_S) & busy_ls;
  assign structural = stall_au | stall_mu | stall_du | stall_ls;

  assign fetch_decode_stall = structural | rob_full | data_hazard | ifence;
  // hold fetch on imem wait or front-end stall
  assign pc_en = ~(imem_busy | fetch_decode_stall);

  // any commit-time fault
  assign exc_valid = fault_insn | mal_insn | illegal_insn | breakpoint | env_m |
                     fault_l | mal_l | fault_s | mal_s;
  // trap, return or interrupt owns the redirect
  assign trap_flow = exc_valid | ret | intr_taken;

  assign branch_jump = jump | (branch & mispredict);
  assign npc_sel     = branch_jump & ~trap_flow;

  // fence still draining caches
  assign ifence_flush = ifence & (~iflushed | ~dflushed);
  assign if_id_flush  = branch_jump | ifence_flush | trap_flow;
  assign id_ex_flush  = branch_jump | ifence_flush | trap_flow;

  // priority encode, env call ranks last
  always_comb begin
    if (mal_insn)          exc_cause = CAUSE_MAL_INSN;
    else if (fault_insn)   exc_cause = CAUSE_FAULT_INSN;
    else if (illegal_insn) exc_cause = CAUSE_ILLEGAL;
    else if (breakpoint)   exc_cause = CAUSE_BREAKPOINT;
    else if (mal_l)        exc_cause = CAUSE_MAL_L;
    else if (fault_l)      exc_cause = CAUSE_FAULT_L;
    else if (mal_s)        exc_cause = CAUSE_MAL_S;
    else if (fault_s)      exc_cause = CAUSE_FAULT_S;
    else                   exc_cause = CAUSE_ENV_M;
  end

  // fetch-side faults report the instruction address
  assign exc_badaddr = (mal_insn | fault_insn) ? badaddr_i : badaddr_d;

  // interrupt loses to a commit fault
  assign intr_req = ext_intr & ~exc_valid;

endmodule

`default_nettype wire

/* prv_exception_ctrl.sv */
`default_nettype none

module prv_exception_ctrl import ooo_hazard_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      cfg_we,
  input  csr_addr_t cfg_addr,
  input  word_t     cfg_wdata,
  input  logic      exc_valid,
  input  logic      intr_req,
  input  logic      ret,
  input  cause_t    exc_cause,
  input  word_t     exc_badaddr,
  input  word_t     commit_pc,
  output logic      insert_pc,
  output logic      intr_taken,
  output word_t     priv_pc,
  output word_t     mepc,
  output word_t     mbadaddr,
  output cause_t    mcause
);

  word_t mtvec;
  logic  mie;
  logic  intr_ok;
  logic  trap;

  // interrupt only when enabled and no fault this cycle
  assign intr_ok = intr_req & mie & ~exc_valid;
  assign trap    = exc_valid | intr_ok;

  // configuration file, vector kept word aligned
  always_ff @(posedge clk) begin
    if (rst) begin
      mtvec <= '0;
      mie   <= 1'b0;
    end else if (cfg_we) begin
      case (cfg_addr)
        CSR_MTVEC: mtvec <= {cfg_wdata[31:2], 2'b00};
        CSR_MIE:   mie   <= cfg_wdata[0];
        default:   ;
      endcase
    end
  end

  // one-cycle insert toward fetch
  always_ff @(posedge clk) begin
    if (rst) begin
      insert_pc  <= 1'b0;
      intr_taken <= 1'b0;
    end else begin
      insert_pc  <= trap | ret;
      intr_taken <= intr_ok;
    end
  end

  // trap state and redirect target
  always_ff @(posedge clk) begin
    if (trap) begin
      mepc     <= commit_pc;
      mcause   <= exc_valid ? exc_cause : CAUSE_INTR;
      mbadaddr <= exc_valid ? exc_badaddr : '0;
      priv_pc  <= mtvec;
    end else if (ret) begin
      // return resumes at the saved pc
      priv_pc <= mepc;
    end
  end

  // a single commit event yields a single insert
  a_insert_pulse: assert property (@(posedge clk) disable iff (rst)
    insert_pc |=> !insert_pc)
    else $error("insert_pc held two cycles");

endmodule

`default_nettype wire

/* tb_ooo_hazard.sv */
`default_nettype none

module tb_ooo_hazard import ooo_hazard_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int RESET_CYCLES = 4;
  // cycle budget per test: reset, stall, branch, trap, interrupt, fence
  localparam int BUDGET = RESET_CYCLES + 20 + 40 + 20 + 30 + 30 + 10;
  // fault bits indexed by cause code
  localparam logic [11:0] FAULT_CODES = 12'h8FF;

  logic clk, rst, dispatch_valid, dmem_done, rob_full, data_hazard, ifence;
  logic iflushed, dflushed, imem_busy, jump, branch, mispredict, ret, ext_intr;
  logic fault_insn, mal_insn, illegal_insn, breakpoint, env_m;
  logic fault_l, mal_l, fault_s, mal_s, cfg_we;
  fu_type_t dispatch_fu;
  csr_addr_t cfg_addr;
  word_t branch_target, commit_pc, badaddr_i, badaddr_d, cfg_wdata;
  word_t pc, mepc, mbadaddr;
  cause_t mcause;
  logic stall_au, stall_mu, stall_du, stall_ls, fetch_decode_stall;
  logic if_id_flush, id_ex_flush, ifence_flush, insert_pc;

  int errors;
  int checks;
  word_t exp_pc;
  word_t vec;
  logic [31:0] rng_state;

  ooo_hazard_top dut (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // run limit, twice the summed budget
  initial begin
    repeat (2 * BUDGET) @(posedge clk);
    $display("timeout: tests did not finish within %0d cycles", 2 * BUDGET);
    $display("TB FAILED");
    $finish;
  end

  // xorshift32
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic word_t rand_word_addr();
    return next_rand() & 32'hFFFF_FFFC;
  endfunction

  // lowest code present wins, env call last
  function automatic cause_t expected_cause(input logic [11:0] m);
    for (int i = 0; i < 8; i++) begin
      if (m[i]) return cause_t'(i);
    end
    return CAUSE_ENV_M;
  endfunction

  function automatic logic stall_of(input fu_type_t fu);
    case (fu)
      ARITH_S:     return stall_au;
      MUL_S:       return stall_mu;
      DIV_S:       return stall_du;
      LOADSTORE_S: return stall_ls;
      default:     return 1'b0;
    endcase
  endfunction

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    $display("%s: %s (%0d errors)", name, (errors == errs_before) ? "ok" : "bad",
             errors - errs_before);
  endtask

  task automatic set_faults(input logic [11:0] m);
    mal_insn     = m[CAUSE_MAL_INSN];
    fault_insn   = m[CAUSE_FAULT_INSN];
    illegal_insn = m[CAUSE_ILLEGAL];
    breakpoint   = m[CAUSE_BREAKPOINT];
    mal_l        = m[CAUSE_MAL_L];
    fault_l      = m[CAUSE_FAULT_L];
    mal_s        = m[CAUSE_MAL_S];
    fault_s      = m[CAUSE_FAULT_S];
    env_m        = m[CAUSE_ENV_M];
  endtask

  // each test starts and ends just after a falling edge, pc == exp_pc
  task automatic step_pc(input logic advance);
    @(negedge clk);
    if (advance) exp_pc = exp_pc + 32'd4;
    check_eq("pc", pc, exp_pc);
  endtask

  task automatic test_reset_fetch();
    int e0;
    e0 = errors;
    check_eq("pc", pc, RESET_PC);
    repeat (3) step_pc(1'b1);
    imem_busy = 1'b1;
    repeat (2) step_pc(1'b0);
    imem_busy = 1'b0;
    rob_full  = 1'b1;
    repeat (2) step_pc(1'b0);
    rob_full = 1'b0;
    step_pc(1'b1);
    report_test("reset and fetch", e0);
  endtask

  task automatic run_stall(input fu_type_t fu, input int lat);
    logic prev_stall;
    prev_stall     = 1'b0;
    dispatch_valid = 1'b1;
    dispatch_fu    = fu;
    for (int i = 0; i <= lat; i++) begin
      step_pc(!prev_stall);
      dispatch_valid = 1'b0;
      // memory handshake in the last busy cycle
      dmem_done = (fu == LOADSTORE_S) && (i == lat - 1);
      #1;
      check_eq("stall", 32'(stall_of(fu)), 32'(i < lat));
      prev_stall = (i < lat);
    end
    dmem_done   = 1'b0;
    dispatch_fu = NONE_S;
    step_pc(1'b1);
  endtask

  task automatic test_struct_stalls();
    int e0;
    e0 = errors;
    run_stall(ARITH_S, int'(ARITH_LATENCY));
    run_stall(MUL_S, int'(MUL_LATENCY));
    run_stall(DIV_S, int'(DIV_LATENCY));
    run_stall(LOADSTORE_S, 3);
    report_test("structural stalls", e0);
  endtask

  task automatic drive_redirect(input logic jmp, input logic br, input logic mp);
    logic taken;
    taken         = jmp | (br & mp);
    jump          = jmp;
    branch        = br;
    mispredict    = mp;
    branch_target = rand_word_addr();
    #1;
    check_eq("if_id_flush", 32'(if_id_flush), 32'(taken));
    check_eq("id_ex_flush", 32'(id_ex_flush), 32'(taken));
    @(negedge clk);
    exp_pc     = taken ? branch_target : exp_pc + 32'd4;
    jump       = 1'b0;
    branch     = 1'b0;
    mispredict = 1'b0;
    check_eq("pc", pc, exp_pc);
  endtask

  task automatic test_branch();
    int e0;
    e0 = errors;
    drive_redirect(1'b1, 1'b0, 1'b0);
    drive_redirect(1'b0, 1'b1, 1'b1);
    drive_redirect(1'b0, 1'b1, 1'b0);
    step_pc(1'b1);
    report_test("branch redirect", e0);
  endtask

  task automatic write_cfg(input csr_addr_t addr, input word_t data);
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = data;
    step_pc(1'b1);
    cfg_we = 1'b0;
  endtask

  // commit event now, insert next cycle, pc at target the cycle after
  task automatic expect_insert(input word_t target, input word_t epc, input cause_t cause,
                               input logic intr);
    step_pc(1'b1);
    set_faults('0);
    jump     = 1'b0;
    ext_intr = 1'b0;
    ret      = 1'b0;
    check_eq("insert_pc", 32'(insert_pc), 32'd1);
    check_eq("mepc", mepc, epc);
    check_eq("mcause", 32'(mcause), 32'(cause));
    // only a taken interrupt still flushes in the insert cycle
    #1;
    check_eq("if_id_flush", 32'(if_id_flush), 32'(intr));
    @(negedge clk);
    exp_pc = target;
    check_eq("insert_pc", 32'(insert_pc), 32'd0);
    check_eq("pc", pc, exp_pc);
  endtask

  task automatic test_exception();
    int e0;
    logic [11:0] m;
    cause_t c;
    e0  = errors;
    vec = rand_word_addr();
    write_cfg(CSR_MTVEC, vec);
    repeat (4) begin
      m = 12'(next_rand()) & FAULT_CODES;
      if (m == '0) m = 12'h800;
      c             = expected_cause(m);
      commit_pc     = rand_word_addr();
      badaddr_i     = next_rand();
      badaddr_d     = next_rand();
      branch_target = rand_word_addr();
      jump          = 1'b1;
      set_faults(m);
      #1;
      check_eq("if_id_flush", 32'(if_id_flush), 32'd1);
      expect_insert(vec, commit_pc, c, 1'b0);
      check_eq("mbadaddr", mbadaddr, (c <= CAUSE_FAULT_INSN) ? badaddr_i : badaddr_d);
    end
    report_test("exception trap", e0);
  endtask

  task automatic test_interrupt();
    int e0;
    word_t saved;
    e0       = errors;
    // mie still clear, interrupt has no effect
    ext_intr = 1'b1;
    step_pc(1'b1);
    ext_intr = 1'b0;
    check_eq("insert_pc", 32'(insert_pc), 32'd0);
    step_pc(1'b1);
    check_eq("insert_pc", 32'(insert_pc), 32'd0);
    write_cfg(CSR_MIE, 32'd1);
    // fault in the same cycle wins
    commit_pc = rand_word_addr();
    ext_intr  = 1'b1;
    set_faults(12'h004);
    expect_insert(vec, commit_pc, CAUSE_ILLEGAL, 1'b0);
    commit_pc = rand_word_addr();
    saved     = commit_pc;
    ext_intr  = 1'b1;
    expect_insert(vec, saved, CAUSE_INTR, 1'b1);
    ret = 1'b1;
    expect_insert(saved, saved, CAUSE_INTR, 1'b0);
    report_test("interrupt and return", e0);
  endtask

  task automatic test_fence();
    int e0;
    e0       = errors;
    ifence   = 1'b1;
    iflushed = 1'b0;
    dflushed = 1'b1;
    #1;
    check_eq("ifence_flush", 32'(ifence_flush), 32'd1);
    check_eq("fetch_decode_stall", 32'(fetch_decode_stall), 32'd1);
    step_pc(1'b0);
    iflushed = 1'b1;
    dflushed = 1'b0;
    #1;
    check_eq("ifence_flush", 32'(ifence_flush), 32'd1);
    step_pc(1'b0);
    dflushed = 1'b1;
    #1;
    check_eq("ifence_flush", 32'(ifence_flush), 32'd0);
    check_eq("fetch_decode_stall", 32'(fetch_decode_stall), 32'd1);
    step_pc(1'b0);
    ifence   = 1'b0;
    iflushed = 1'b0;
    dflushed = 1'b0;
    step_pc(1'b1);
    step_pc(1'b1);
    report_test("fence", e0);
  endtask

  initial begin
    errors         = 0;
    checks         = 0;
    rng_state      = 32'd99239;
    exp_pc         = RESET_PC;
    vec            = '0;
    rst            = 1'b1;
    dispatch_valid = 1'b0;
    dispatch_fu    = NONE_S;
    dmem_done      = 1'b0;
    rob_full       = 1'b0;
    data_hazard    = 1'b0;
    ifence         = 1'b0;
    iflushed       = 1'b0;
    dflushed       = 1'b0;
    imem_busy      = 1'b0;
    jump           = 1'b0;
    branch         = 1'b0;
    mispredict     = 1'b0;
    branch_target  = '0;
    ret            = 1'b0;
    commit_pc      = '0;
    badaddr_i      = '0;
    badaddr_d      = '0;
    ext_intr       = 1'b0;
    cfg_we         = 1'b0;
    cfg_addr       = CSR_MTVEC;
    cfg_wdata      = '0;
    set_faults('0);
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset_fetch();
    test_struct_stalls();
    test_branch();
    test_exception();
    test_interrupt();
    test_fence();
    $display("totals: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
